/* list.f */
design/ant_pkg.sv
design/command_arbiter.sv
design/command_datapath.sv
design/ant_draw.sv
design/ant_update.sv
design/ant_core.sv
testbench/ant_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ant core testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module ant_core_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vant_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
exit 1

/* testbench/ant_core_tb.sv */
`timescale 1ns/1ps

module ant_core_tb;
    import ant_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;
    localparam int BLOCK_PIXELS   = ANT_WIDTH * ANT_HEIGHT;

    logic       clock;
    logic       resetn;
    logic       draw_start;
    ant_id_t    draw_id;
    logic       draw_finished;
    logic       update_start;
    ant_id_t    update_id;
    direction_t rand_dir;
    logic       update_finished;
    logic       plot;
    x_coord_t   plot_x;
    y_coord_t   plot_y;
    colour_t    plot_colour;

    int          errors;
    int          plots_seen;
    logic [31:0] lfsr;
    x_coord_t    model_x [ANT_COUNT];
    y_coord_t    model_y [ANT_COUNT];
    x_coord_t    seen_x [$];
    y_coord_t    seen_y [$];
    time         seen_t [$];

    ant_core dut0 (
        .clock           (clock),
        .resetn          (resetn),
        .draw_start      (draw_start),
        .draw_id         (draw_id),
        .draw_finished   (draw_finished),
        .update_start    (update_start),
        .update_id       (update_id),
        .rand_dir        (rand_dir),
        .update_finished (update_finished),
        .plot            (plot),
        .plot_x          (plot_x),
        .plot_y          (plot_y),
        .plot_colour     (plot_colour)
    );

    always #20 clock = ~clock;

    // Capture each plotted pixel
    always @(negedge clock) begin
        if (resetn && plot) begin
            seen_x.push_back(plot_x);
            seen_y.push_back(plot_y);
            seen_t.push_back($time);
            plots_seen++;
        end
    end

    assert property (@(posedge clock) disable iff (!resetn) plot |-> plot_colour == ANT_COLOUR)
        else begin
            errors++;
            $display("ERR %0t plot_colour expected %0d actual %0d",
                     $time, ANT_COLOUR, $sampled(plot_colour));
        end

    // Pixels only appear while a draw is running
    assert property (@(posedge clock) disable iff (!resetn) plot |-> !draw_finished)
        else begin
            errors++;
            $display("Plot strobe seen at %0t while no draw was running", $time);
        end

    assert property (@(posedge clock) disable iff (!resetn)
        draw_start && draw_finished |=> !draw_finished)
        else begin
            errors++;
            $display("draw_finished did not drop after a start at %0t", $time);
        end

    assert property (@(posedge clock) disable iff (!resetn)
        update_start && update_finished |=> !update_finished)
        else begin
            errors++;
            $display("update_finished did not drop after a start at %0t", $time);
        end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_dir(output direction_t dir);
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_next(lfsr);
            dir[i] = lfsr[0];
        end
    endtask

    function automatic void apply_move(input ant_id_t ant, input direction_t dir);
        case (dir)
            DIR_LEFT:  model_x[ant] = model_x[ant] - 8'd1;
            DIR_RIGHT: model_x[ant] = model_x[ant] + 8'd1;
            DIR_UP:    model_y[ant] = model_y[ant] - 7'd1;
            default:   model_y[ant] = model_y[ant] + 7'd1;
        endcase
    endfunction

    task automatic clear_plots();
        seen_x.delete();
        seen_y.delete();
        seen_t.delete();
    endtask

    task automatic start_ops(input bit do_draw, input ant_id_t d_ant,
                             input bit do_update, input ant_id_t u_ant, input direction_t dir);
        @(posedge clock);
        #2;
        draw_start   = do_draw;
        draw_id      = d_ant;
        update_start = do_update;
        update_id    = u_ant;
        rand_dir     = dir;
        @(posedge clock);
        #2;
        draw_start   = 1'b0;
        update_start = 1'b0;
    endtask

    task automatic wait_idle(input bit on_draw, input bit on_update);
        int cycles;
        cycles = 0;
        while (((on_draw && !draw_finished) || (on_update && !update_finished)) &&
               cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (on_draw && !draw_finished) begin
            errors++;
            $display("Hang: draw_finished stayed low for %0d cycles", TIMEOUT_CYCLES);
        end
        if (on_update && !update_finished) begin
            errors++;
            $display("Hang: update_finished stayed low for %0d cycles", TIMEOUT_CYCLES);
        end
    endtask

    // Row-major block starting one pixel up and left of the ant
    task automatic check_block(input ant_id_t ant);
        x_coord_t exp_x;
        y_coord_t exp_y;
        int       n;
        n = 0;
        assert (seen_x.size() == BLOCK_PIXELS) else begin
            errors++;
            $display("Draw of ant %0d gave %0d plots instead of %0d",
                     ant, seen_x.size(), BLOCK_PIXELS);
        end
        for (int dy = 0; dy < ANT_HEIGHT; dy++) begin
            for (int dx = 0; dx < ANT_WIDTH; dx++) begin
                exp_x = model_x[ant] - 8'd1 + x_coord_t'(dx);
                exp_y = model_y[ant] - 7'd1 + y_coord_t'(dy);
                if (n < seen_x.size()) begin
                    assert (seen_x[n] == exp_x) else begin
                        errors++;
                        $display("ERR %0t plot_x expected %0d actual %0d",
                                 seen_t[n], exp_x, seen_x[n]);
                    end
                    assert (seen_y[n] == exp_y) else begin
                        errors++;
                        $display("ERR %0t plot_y expected %0d actual %0d",
                                 seen_t[n], exp_y, seen_y[n]);
                    end
                end
                n++;
            end
        end
    endtask

    task automatic draw_ant(input ant_id_t ant);
        clear_plots();
        start_ops(1'b1, ant, 1'b0, 2'd0, 2'd0);
        wait_idle(1'b1, 1'b0);
        check_block(ant);
    endtask

    task automatic update_ant(input ant_id_t ant, input direction_t dir);
        start_ops(1'b0, 2'd0, 1'b1, ant, dir);
        wait_idle(1'b0, 1'b1);
        apply_move(ant, dir);
    endtask

    task automatic check_reset_idle();
        repeat (4) begin
            @(negedge clock);
            assert (draw_finished) else begin
                errors++;
                $display("ERR %0t draw_finished expected 1 actual %0b",
                         $time, draw_finished);
            end
            assert (update_finished) else begin
                errors++;
                $display("ERR %0t update_finished expected 1 actual %0b",
                         $time, update_finished);
            end
            assert (!plot) else begin
                errors++;
                $display("ERR %0t plot expected 0 actual %0b", $time, plot);
            end
        end
    endtask

    initial begin
        direction_t dir;
        int         steps;
        clock        = 1'b0;
        resetn       = 1'b0;
        draw_start   = 1'b0;
        draw_id      = '0;
        update_start = 1'b0;
        update_id    = '0;
        rand_dir     = '0;
        errors       = 0;
        plots_seen   = 0;
        lfsr         = 32'h7f6ff78b;
        for (int a = 0; a < ANT_COUNT; a++) begin
            model_x[a] = START_X;
            model_y[a] = START_Y;
        end
        repeat (4) @(posedge clock);
        #2;
        resetn = 1'b1;

        check_reset_idle();

        // Fresh ants sit at the start position
        for (int a = 0; a < ANT_COUNT; a++) begin
            draw_ant(ant_id_t'(a));
        end

        // Random walk with the ants interleaved
        for (int r = 0; r < 6; r++) begin
            for (int a = 0; a < ANT_COUNT; a++) begin
                take_dir(dir);
                update_ant(ant_id_t'(a), dir);
            end
        end
        for (int a = 0; a < ANT_COUNT; a++) begin
            draw_ant(ant_id_t'(a));
        end

        // Draw of ant 0 and update of ant 2 on the same cycle
        take_dir(dir);
        clear_plots();
        start_ops(1'b1, 2'd0, 1'b1, 2'd2, dir);
        wait_idle(1'b1, 1'b1);
        check_block(2'd0);
        apply_move(2'd2, dir);
        draw_ant(2'd2);

        // Walk ant 3 left to x of 0, then one more step wraps to 255
        steps = int'(model_x[3]);
        repeat (steps) update_ant(2'd3, DIR_LEFT);
        draw_ant(2'd3);
        update_ant(2'd3, DIR_LEFT);
        draw_ant(2'd3);

        repeat (2) @(negedge clock);
        $display("Errors: %0d, plots captured: %0d", errors, plots_seen);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* design/ant_core.sv */
`timescale 1ns/1ps

module ant_core (
    input  logic                clock,
    input  logic                resetn,
    input  logic                draw_start,
    input  ant_pkg::ant_id_t    draw_id,
    output logic                draw_finished,
    input  logic                update_start,
    input  ant_pkg::ant_id_t    update_id,
    input  ant_pkg::direction_t rand_dir,
    output logic                update_finished,
    output logic                plot,
    output ant_pkg::x_coord_t   plot_x,
    output ant_pkg::y_coord_t   plot_y,
    output ant_pkg::colour_t    plot_colour
);
    import ant_pkg::*;

    logic     draw_cmd_start;
    command_t draw_cmd;
    logic     draw_cmd_finished;
    logic     update_cmd_start;
    command_t update_cmd;
    logic     update_cmd_finished;
    logic     exec;
    command_t exec_cmd;
    logic     exec_done;
    result_t  result;

    ant_draw draw0 (
        .clock        (clock),
        .resetn       (resetn),
        .start        (draw_start),
        .id           (draw_id),
        .finished     (draw_finished),
        .cmd_start    (draw_cmd_start),
        .cmd          (draw_cmd),
        .cmd_finished (draw_cmd_finished),
        .cmd_result   (result)
    );

    ant_update update0 (
        .clock        (clock),
        .resetn       (resetn),
        .start        (update_start),
        .id           (update_id),
        .rand_dir     (rand_dir),
        .finished     (update_finished),
        .cmd_start    (update_cmd_start),
        .cmd          (update_cmd),
        .cmd_finished (update_cmd_finished),
        .cmd_result   (result)
    );

    // Both engines share one datapath
    command_arbiter arbiter0 (
        .clock               (clock),
        .resetn              (resetn),
        .draw_cmd_start      (draw_cmd_start),
        .draw_cmd            (draw_cmd),
        .draw_cmd_finished   (draw_cmd_finished),
        .update_cmd_start    (update_cmd_start),
        .update_cmd          (update_cmd),
        .update_cmd_finished (update_cmd_finished),
        .exec                (exec),
        .exec_cmd            (exec_cmd),
        .exec_done           (exec_done)
    );

    command_datapath datapath0 (
        .clock       (clock),
        .resetn      (resetn),
        .exec        (exec),
        .exec_cmd    (exec_cmd),
        .done        (exec_done),
        .result      (result),
        .plot        (plot),
        .plot_x      (plot_x),
        .plot_y      (plot_y),
        .plot_colour (plot_colour)
    );

endmodule

/* design/ant_update.sv */
`timescale 1ns/1ps

module ant_update (
    input  logic                clock,
    input  logic                resetn,
    input  logic                start,
    input  ant_pkg::ant_id_t    id,
    input  ant_pkg::direction_t rand_dir,
    output logic                finished,
    output logic                cmd_start,
    output ant_pkg::command_t   cmd,
    input  logic                cmd_finished,
    input  ant_pkg::result_t    cmd_result
);
    import ant_pkg::*;

    update_state_t state;
    ant_id_t       ant;
    direction_t    dir;
    x_coord_t      x;
    y_coord_t      y;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= UPD_STANDBY;
            finished  <= 1'b1;
            cmd_start <= 1'b0;
        end else begin
            case (state)
                UPD_STANDBY: begin
                    if (start) begin
                        finished <= 1'b0;
                        state    <= UPD_LOAD_X_START;
                    end
                end
                UPD_LOAD_X_START, UPD_LOAD_Y_START, UPD_STORE_X_START, UPD_STORE_Y_START,
                UPD_LOAD_X_DELAY, UPD_LOAD_Y_DELAY, UPD_STORE_X_DELAY, UPD_STORE_Y_DELAY: begin
                    cmd_start <= 1'b1;
                    state     <= update_state_t'(state + 4'd1);
                end
                UPD_LOAD_X_WAIT, UPD_LOAD_Y_WAIT, UPD_STORE_X_WAIT: begin
                    cmd_start <= 1'b0;
                    if (cmd_finished) begin
                        state <= update_state_t'(state + 4'd1);
                    end
                end
                UPD_MOVE: state <= UPD_STORE_X_START;
                UPD_STORE_Y_WAIT: begin
                    cmd_start <= 1'b0;
                    if (cmd_finished) begin
                        finished <= 1'b1;
                        state    <= UPD_STANDBY;
                    end
                end
                default: state <= UPD_STANDBY;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (state)
            UPD_STANDBY: begin
                // Direction is fixed for the whole update
                if (start) begin
                    ant <= id;
                    dir <= rand_dir;
                end
            end
            UPD_LOAD_X_START: cmd <= mem_command(OPCODE_MEMREAD, ant, FIELD_X, 8'd0);
            UPD_LOAD_Y_START: cmd <= mem_command(OPCODE_MEMREAD, ant, FIELD_Y, 8'd0);
            UPD_LOAD_X_WAIT: begin
                if (cmd_finished) begin
                    x <= x_coord_t'(cmd_result);
                end
            end
            UPD_LOAD_Y_WAIT: begin
                if (cmd_finished) begin
                    y <= y_coord_t'(cmd_result);
                end
            end
            UPD_MOVE: begin
                // Steps wrap at the coordinate width
                case (dir)
                    DIR_LEFT:  x <= x - 8'd1;
                    DIR_RIGHT: x <= x + 8'd1;
                    DIR_UP:    y <= y - 7'd1;
                    DIR_DOWN:  y <= y + 7'd1;
                    default:   ;
                endcase
            end
            UPD_STORE_X_START: cmd <= mem_command(OPCODE_MEMWRITE, ant, FIELD_X, x);
            UPD_STORE_Y_START: cmd <= mem_command(OPCODE_MEMWRITE, ant, FIELD_Y, x_coord_t'(y));
            default: ;
        endcase
    end

endmodule

/* design/ant_draw.sv */
`timescale 1ns/1ps

module ant_draw (
    input  logic              clock,
    input  logic              resetn,
    input  logic              start,
    input  ant_pkg::ant_id_t  id,
    output logic              finished,
    output logic              cmd_start,
    output ant_pkg::command_t cmd,
    input  logic              cmd_finished,
    input  ant_pkg::result_t  cmd_result
);
    import ant_pkg::*;

    draw_state_t state;
    ant_id_t     ant;
    x_coord_t    x;
    y_coord_t    y;
    x_coord_t    dx;
    y_coord_t    dy;
    logic        last_col;
    logic        last_row;

    assign last_col = (dx == x_coord_t'(ANT_WIDTH - 1));
    assign last_row = (dy == y_coord_t'(ANT_HEIGHT - 1));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= DRAW_STANDBY;
            finished  <= 1'b1;
            cmd_start <= 1'b0;
        end else begin
            case (state)
                DRAW_STANDBY: begin
                    if (start) begin
                        finished <= 1'b0;
                        state    <= DRAW_LOAD_X_START;
                    end
                end
                DRAW_LOAD_X_START, DRAW_LOAD_Y_START, DRAW_PIXEL_START: begin
                    cmd_start <= 1'b1;
                    state     <= draw_state_t'(state + 4'd1);
                end
                DRAW_LOAD_X_DELAY, DRAW_LOAD_Y_DELAY, DRAW_PIXEL_DELAY: begin
                    cmd_start <= 1'b1;
                    state     <= draw_state_t'(state + 4'd1);
                end
                DRAW_LOAD_X_WAIT, DRAW_LOAD_Y_WAIT: begin
                    cmd_start <= 1'b0;
                    if (cmd_finished) begin
                        state <= draw_state_t'(state + 4'd1);
                    end
                end
                DRAW_PIXEL_WAIT: begin
                    cmd_start <= 1'b0;
                    if (cmd_finished) begin
                        if (last_col && last_row) begin
                            finished <= 1'b1;
                            state    <= DRAW_STANDBY;
                        end else begin
                            state <= DRAW_PIXEL_START;
                        end
                    end
                end
                default: state <= DRAW_STANDBY;
            endcase
        end
    end

    // Position, pixel offsets and command word
    always_ff @(posedge clock) begin
        case (state)
            DRAW_STANDBY: begin
                if (start) begin
                    ant <= id;
                    dx  <= '0;
                    dy  <= '0;
                end
            end
            DRAW_LOAD_X_START: cmd <= mem_command(OPCODE_MEMREAD, ant, FIELD_X, 8'd0);
            DRAW_LOAD_Y_START: cmd <= mem_command(OPCODE_MEMREAD, ant, FIELD_Y, 8'd0);
            DRAW_LOAD_X_WAIT: begin
                // Block starts one pixel left of the ant
                if (cmd_finished) begin
                    x <= x_coord_t'(cmd_result) - 8'd1;
                end
            end
            DRAW_LOAD_Y_WAIT: begin
                if (cmd_finished) begin
                    y <= y_coord_t'(cmd_result) - 7'd1;
                end
            end
            DRAW_PIXEL_START: cmd <= {1'b0, ANT_COLOUR, y + dy, x + dx, FIELD_X, ant, OPCODE_DRAW};
            DRAW_PIXEL_WAIT: begin
                // Row-major walk over the block
                if (cmd_finished) begin
                    if (last_col) begin
                        dx <= '0;
                        dy <= dy + 7'd1;
                    end else begin
                        dx <= dx + 8'd1;
                    end
                end
            end
            default: ;
        endcase
    end

    assert property (@(posedge clock) disable iff (!resetn) cmd_start [*2] |=> !cmd_start)
        else $error("draw cmd_start held longer than two cycles");

endmodule

/* design/command_datapath.sv */
`timescale 1ns/1ps

module command_datapath (
    input  logic              clock,
    input  logic              resetn,
    input  logic              exec,
    input  ant_pkg::command_t exec_cmd,
    output logic              done,
    output ant_pkg::result_t  result,
    output logic              plot,
    output ant_pkg::x_coord_t plot_x,
    output ant_pkg::y_coord_t plot_y,
    output ant_pkg::colour_t  plot_colour
);
    import ant_pkg::*;

    opcode_t  op;
    ant_id_t  ant;
    field_t   field;
    x_coord_t data;
    y_coord_t draw_y;
    colour_t  colour;
    x_coord_t mem_x [ANT_COUNT];
    y_coord_t mem_y [ANT_COUNT];

    // Command word decode
    assign op     = exec_cmd[CMD_OP_LSB +: $bits(opcode_t)];
    assign ant    = exec_cmd[CMD_ID_LSB +: $bits(ant_id_t)];
    assign field  = exec_cmd[CMD_FIELD_LSB];
    assign data   = exec_cmd[CMD_DATA_LSB +: $bits(x_coord_t)];
    assign draw_y = exec_cmd[CMD_DRAW_Y_LSB +: $bits(y_coord_t)];
    assign colour = exec_cmd[CMD_COLOUR_LSB +: $bits(colour_t)];

    always_ff @(posedge clock) begin
        if (!resetn) begin
            done <= 1'b1;
            plot <= 1'b0;
            for (int i = 0; i < ANT_COUNT; i++) begin
                mem_x[i] <= START_X;
                mem_y[i] <= START_Y;
            end
        end else begin
            // Done drops for the single cycle after exec
            done <= !exec;
            plot <= exec && (op == OPCODE_DRAW);
            if (exec && (op == OPCODE_MEMWRITE)) begin
                if (field == FIELD_X) begin
                    mem_x[ant] <= data;
                end else begin
                    mem_y[ant] <= y_coord_t'(data);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (exec) begin
            if (op == OPCODE_MEMREAD) begin
                result <= (field == FIELD_X) ? mem_x[ant] : result_t'(mem_y[ant]);
            end
            plot_x      <= data;
            plot_y      <= draw_y;
            plot_colour <= colour;
        end
    end

    assert property (@(posedge clock) disable iff (!resetn)
        plot |-> $past(exec && (op == OPCODE_DRAW)))
        else $error("plot without a draw command on the previous cycle");

endmodule

/* design/command_arbiter.sv */
`timescale 1ns/1ps

module command_arbiter (
    input  logic              clock,
    input  logic              resetn,
    input  logic              draw_cmd_start,
    input  ant_pkg::command_t draw_cmd,
    output logic              draw_cmd_finished,
    input  logic              update_cmd_start,
    input  ant_pkg::command_t update_cmd,
    output logic              update_cmd_finished,
    output logic              exec,
    output ant_pkg::command_t exec_cmd,
    input  logic              exec_done
);
    import ant_pkg::*;

    logic     draw_start_d;
    logic     update_start_d;
    logic     draw_rise;
    logic     update_rise;
    logic     draw_pending;
    logic     update_pending;
    logic     grant_draw;
    logic     grant_update;
    logic     granted;
    logic     can_grant;
    logic     complete;
    command_t draw_cmd_q;
    command_t update_cmd_q;

    assign draw_rise   = draw_cmd_start && !draw_start_d;
    assign update_rise = update_cmd_start && !update_start_d;
    assign granted     = grant_draw || grant_update;
    assign can_grant   = !granted && exec_done;
    // Done is high again and no exec is in flight
    assign complete    = granted && exec_done && !exec;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            draw_start_d        <= 1'b0;
            update_start_d      <= 1'b0;
            draw_pending        <= 1'b0;
            update_pending      <= 1'b0;
            grant_draw          <= 1'b0;
            grant_update        <= 1'b0;
            exec                <= 1'b0;
            draw_cmd_finished   <= 1'b1;
            update_cmd_finished <= 1'b1;
        end else begin
            draw_start_d   <= draw_cmd_start;
            update_start_d <= update_cmd_start;
            exec           <= 1'b0;

            if (draw_rise) begin
                draw_pending      <= 1'b1;
                draw_cmd_finished <= 1'b0;
            end
            if (update_rise) begin
                update_pending      <= 1'b1;
                update_cmd_finished <= 1'b0;
            end

            // Update engine wins when both are waiting
            if (can_grant) begin
                if (update_pending) begin
                    grant_update   <= 1'b1;
                    update_pending <= 1'b0;
                    exec           <= 1'b1;
                end else if (draw_pending) begin
                    grant_draw   <= 1'b1;
                    draw_pending <= 1'b0;
                    exec         <= 1'b1;
                end
            end

            if (complete) begin
                grant_draw   <= 1'b0;
                grant_update <= 1'b0;
                if (grant_draw) begin
                    draw_cmd_finished <= 1'b1;
                end
                if (grant_update) begin
                    update_cmd_finished <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (draw_rise) begin
            draw_cmd_q <= draw_cmd;
        end
        if (update_rise) begin
            update_cmd_q <= update_cmd;
        end
        if (can_grant) begin
            exec_cmd <= update_pending ? update_cmd_q : draw_cmd_q;
        end
    end

    assert property (@(posedge clock) disable iff (!resetn) exec |-> exec_done)
        else $error("exec issued while the datapath was busy");

    assert property (@(posedge clock) disable iff (!resetn) !(grant_draw && grant_update))
        else $error("both engines granted at once");

endmodule

/* design/ant_pkg.sv */
package ant_pkg;

    localparam int ANT_COUNT = 4;

    typedef logic [1:0] ant_id_t;
    typedef logic [7:0] x_coord_t;
    typedef logic [6:0] y_coord_t;
    typedef logic [2:0] colour_t;
    typedef logic [1:0] opcode_t;
    typedef logic       field_t;
    typedef logic [23:0] command_t;
    typedef logic [7:0] result_t;
    typedef logic [1:0] direction_t;

    localparam opcode_t OPCODE_MEMREAD  = 2'd1;
    localparam opcode_t OPCODE_MEMWRITE = 2'd2;
    localparam opcode_t OPCODE_DRAW     = 2'd3;

    localparam field_t FIELD_X = 1'b0;
    localparam field_t FIELD_Y = 1'b1;

    // Bit offsets of the command word fields
    localparam int CMD_OP_LSB     = 0;
    localparam int CMD_ID_LSB     = 2;
    localparam int CMD_FIELD_LSB  = 4;
    localparam int CMD_DATA_LSB   = 5;
    localparam int CMD_DRAW_Y_LSB = 13;
    localparam int CMD_COLOUR_LSB = 20;

    localparam int ANT_WIDTH  = 2;
    localparam int ANT_HEIGHT = 2;
    localparam colour_t ANT_COLOUR = 3'b110;

    localparam x_coord_t START_X = 8'd80;
    localparam y_coord_t START_Y = 7'd60;

    localparam direction_t DIR_LEFT  = 2'd0;
    localparam direction_t DIR_RIGHT = 2'd1;
    localparam direction_t DIR_UP    = 2'd2;
    localparam direction_t DIR_DOWN  = 2'd3;

    typedef enum logic [3:0] {
        DRAW_STANDBY,
        DRAW_LOAD_X_START,
        DRAW_LOAD_X_DELAY,
        DRAW_LOAD_X_WAIT,
        DRAW_LOAD_Y_START,
        DRAW_LOAD_Y_DELAY,
        DRAW_LOAD_Y_WAIT,
        DRAW_PIXEL_START,
        DRAW_PIXEL_DELAY,
        DRAW_PIXEL_WAIT
    } draw_state_t;

    typedef enum logic [3:0] {
        UPD_STANDBY,
        UPD_LOAD_X_START,
        UPD_LOAD_X_DELAY,
        UPD_LOAD_X_WAIT,
        UPD_LOAD_Y_START,
        UPD_LOAD_Y_DELAY,
        UPD_LOAD_Y_WAIT,
        UPD_MOVE,
        UPD_STORE_X_START,
        UPD_STORE_X_DELAY,
        UPD_STORE_X_WAIT,
        UPD_STORE_Y_START,
        UPD_STORE_Y_DELAY,
        UPD_STORE_Y_WAIT
    } update_state_t;

    // Memory read or write command with the draw fields left at zero
    function automatic command_t mem_command(opcode_t op, ant_id_t ant, field_t field,
                                             x_coord_t data);
        return {1'b0, 3'd0, 7'd0, data, field, ant, op};
    endfunction

endpackage
